/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module mont_mul_tb -f mont_mul.f
	./obj_dir/Vmont_mul_tb | tee /dev/stderr | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

/* mont_mul.f */
rtl/mont_pkg.sv
rtl/mont_ctrl.sv
rtl/digit_counter.sv
rtl/operand_table.sv
rtl/accumulator.sv
rtl/mont_mul_top.sv
tests/tb_clock.sv
tests/mont_mul_assert.sv
tests/mont_mul_tb.sv

/* rtl/accumulator.sv */
`timescale 1ns/1ps

module accumulator #(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             resetn,
    input  mont_pkg::ctrl_t  ctrl,
    input  logic [WIDTH+1:0] addend,
    output logic [1:0]       c_low,
    output logic [WIDTH-1:0] result
);

    // acc stays below 2m between digits, sums below 8m
    logic [WIDTH+2:0] acc;
    logic [WIDTH+2:0] sum;
    logic [WIDTH+3:0] diff; // extra msb is the borrow

    assign sum  = acc + {1'b0, addend};
    assign diff = {1'b0, acc} - {2'b00, addend};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc <= '0;
        end else begin
            case (ctrl.op)
                mont_pkg::OP_CLEAR: acc <= '0;
                mont_pkg::OP_ADD_A: acc <= sum;
                mont_pkg::OP_ADD_M: begin
                    // two low bits of sum are zero here
                    acc <= {2'b00, sum[WIDTH+2:2]};
                end
                mont_pkg::OP_SUB_M: begin
                    if (!diff[WIDTH+3]) begin
                        acc <= diff[WIDTH+2:0];
                    end
                end
                default: acc <= acc;
            endcase
        end
    end

    assign c_low  = acc[1:0]; // read by the q selection during ADD_M
    assign result = acc[WIDTH-1:0];

endmodule

/* rtl/digit_counter.sv */
`timescale 1ns/1ps

module digit_counter #(
    parameter int WIDTH = 64
) (
    input  logic            clk,
    input  logic            resetn,
    input  mont_pkg::ctrl_t ctrl,
    output logic            last
);

    localparam int CW = $clog2(WIDTH / 2 + 1);

    logic [CW-1:0] count; // digits of a still to process

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (ctrl.load_ops) begin
            count <= CW'(WIDTH / 2);
        end else if (ctrl.next_digit && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // one digit left
    assign last = (count == CW'(1));

endmodule

/* rtl/mont_ctrl.sv */
`timescale 1ns/1ps

module mont_ctrl (
    input  logic            clk,
    input  logic            resetn,
    input  logic            start,
    input  logic            last,
    output mont_pkg::ctrl_t ctrl,
    output logic            done,
    output logic            busy
);

    mont_pkg::ctrl_state_t state;
    mont_pkg::ctrl_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= mont_pkg::ST_IDLE;
            done  <= 1'b0;
            busy  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= (state_nxt == mont_pkg::ST_DONE); // single cycle, DONE lasts one
            busy  <= (state_nxt != mont_pkg::ST_IDLE);
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            mont_pkg::ST_IDLE: begin
                if (start) begin
                    state_nxt = mont_pkg::ST_LOAD; // start only seen here
                end
            end
            mont_pkg::ST_LOAD:  state_nxt = mont_pkg::ST_PREP;
            mont_pkg::ST_PREP:  state_nxt = mont_pkg::ST_ADD_A;
            mont_pkg::ST_ADD_A: state_nxt = mont_pkg::ST_ADD_M;
            mont_pkg::ST_ADD_M: begin
                // leave after the final digit
                state_nxt = last ? mont_pkg::ST_SUB : mont_pkg::ST_ADD_A;
            end
            mont_pkg::ST_SUB:   state_nxt = mont_pkg::ST_DONE;
            mont_pkg::ST_DONE:  state_nxt = mont_pkg::ST_IDLE;
            default:            state_nxt = mont_pkg::ST_IDLE;
        endcase
    end

    // one accumulator op per state plus the strobes
    always_comb begin
        ctrl    = '0;
        ctrl.op = mont_pkg::OP_HOLD;
        case (state)
            mont_pkg::ST_LOAD: begin
                ctrl.op       = mont_pkg::OP_CLEAR;
                ctrl.load_ops = 1'b1;
            end
            mont_pkg::ST_PREP: begin
                ctrl.build_mult = 1'b1;
            end
            mont_pkg::ST_ADD_A: begin
                ctrl.op = mont_pkg::OP_ADD_A;
            end
            mont_pkg::ST_ADD_M: begin
                ctrl.op         = mont_pkg::OP_ADD_M;
                ctrl.next_digit = 1'b1; // digit consumed
            end
            mont_pkg::ST_SUB: begin
                ctrl.op = mont_pkg::OP_SUB_M;
            end
            default: begin
                ctrl.op = mont_pkg::OP_HOLD;
            end
        endcase
    end

endmodule

/* rtl/mont_mul_top.sv */
`timescale 1ns/1ps

module mont_mul_top #(
    parameter int WIDTH = 64 // even
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    input  logic [WIDTH-1:0] in_m,
    output logic [WIDTH-1:0] result,
    output logic             done,
    output logic             busy
);

    mont_pkg::ctrl_t  ctrl;
    logic             last;
    logic [WIDTH+1:0] addend;
    logic [1:0]       c_low;

    mont_ctrl u_ctrl (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .last   (last),
        .ctrl   (ctrl),
        .done   (done),
        .busy   (busy)
    );

    digit_counter #(.WIDTH(WIDTH)) u_counter (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (ctrl),
        .last   (last)
    );

    operand_table #(.WIDTH(WIDTH)) u_table (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (ctrl),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .c_low  (c_low),
        .addend (addend)
    );

    accumulator #(.WIDTH(WIDTH)) u_acc (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (ctrl),
        .addend (addend),
        .c_low  (c_low),
        .result (result)
    );

endmodule

/* rtl/mont_pkg.sv */
package mont_pkg;

    // sequencing states of the controller
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_LOAD  = 3'd1,
        ST_PREP  = 3'd2,
        ST_ADD_A = 3'd3,
        ST_ADD_M = 3'd4,
        ST_SUB   = 3'd5,
        ST_DONE  = 3'd6
    } ctrl_state_t;

    // accumulator operation
    typedef enum logic [2:0] {
        OP_HOLD  = 3'd0,
        OP_CLEAR = 3'd1,
        OP_ADD_A = 3'd2, // add digit multiple of b
        OP_ADD_M = 3'd3, // add multiple of m, then shift right by two
        OP_SUB_M = 3'd4  // subtract m when no borrow
    } acc_op_t;

    // which stored multiple feeds the addend
    typedef enum logic [2:0] {
        SEL_ZERO = 3'd0,
        SEL_B1   = 3'd1,
        SEL_B2   = 3'd2,
        SEL_B3   = 3'd3,
        SEL_M1   = 3'd4,
        SEL_M2   = 3'd5,
        SEL_M3   = 3'd6
    } mult_sel_t;

    // control bundle from mont_ctrl to the data modules, 6 bits
    typedef struct packed {
        acc_op_t op;
        logic    load_ops;   // capture a, b and m
        logic    build_mult; // form 2b, 3b, 2m, 3m
        logic    next_digit; // shift a and step the counter
    } ctrl_t;

endpackage

/* rtl/operand_table.sv */
`timescale 1ns/1ps

module operand_table #(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             resetn,
    input  mont_pkg::ctrl_t  ctrl,
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    input  logic [WIDTH-1:0] in_m,
    input  logic [1:0]       c_low,
    output logic [WIDTH+1:0] addend
);

    logic [WIDTH-1:0] a_q; // scanned two bits at a time from the lsb end
    logic [WIDTH+1:0] b1;
    logic [WIDTH+1:0] b2;
    logic [WIDTH+1:0] b3;
    logic [WIDTH+1:0] m1;
    logic [WIDTH+1:0] m2;
    logic [WIDTH+1:0] m3;
    logic [1:0]       q;
    mont_pkg::mult_sel_t sel;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_q <= '0;
            b1  <= '0;
            b2  <= '0;
            b3  <= '0;
            m1  <= '0;
            m2  <= '0;
            m3  <= '0;
        end else begin
            if (ctrl.load_ops) begin
                a_q <= in_a;
                b1  <= {2'b00, in_b};
                m1  <= {2'b00, in_m};
            end else if (ctrl.next_digit) begin
                a_q <= {2'b00, a_q[WIDTH-1:2]};
            end
            if (ctrl.build_mult) begin
                b2 <= b1 << 1;
                b3 <= b1 + (b1 << 1); // fits, b < 2^WIDTH
                m2 <= m1 << 1;
                m3 <= m1 + (m1 << 1);
            end
        end
    end

    // m odd so m is its own inverse mod 4, q = -c*m mod 4
    assign q = 2'd0 - c_low * m1[1:0];

    always_comb begin
        sel = mont_pkg::SEL_ZERO;
        case (ctrl.op)
            mont_pkg::OP_ADD_A: begin
                case (a_q[1:0])
                    2'd1:    sel = mont_pkg::SEL_B1;
                    2'd2:    sel = mont_pkg::SEL_B2;
                    2'd3:    sel = mont_pkg::SEL_B3;
                    default: sel = mont_pkg::SEL_ZERO;
                endcase
            end
            mont_pkg::OP_ADD_M: begin
                case (q)
                    2'd1:    sel = mont_pkg::SEL_M1;
                    2'd2:    sel = mont_pkg::SEL_M2;
                    2'd3:    sel = mont_pkg::SEL_M3;
                    default: sel = mont_pkg::SEL_ZERO; // low bits already zero
                endcase
            end
            mont_pkg::OP_SUB_M: sel = mont_pkg::SEL_M1;
            default:            sel = mont_pkg::SEL_ZERO;
        endcase
    end

    always_comb begin
        case (sel)
            mont_pkg::SEL_B1: addend = b1;
            mont_pkg::SEL_B2: addend = b2;
            mont_pkg::SEL_B3: addend = b3;
            mont_pkg::SEL_M1: addend = m1;
            mont_pkg::SEL_M2: addend = m2;
            mont_pkg::SEL_M3: addend = m3;
            default:          addend = '0;
        endcase
    end

endmodule

/* tests/mont_mul_assert.sv */
`timescale 1ns/1ps

module mont_mul_assert #(
    parameter int WIDTH = 64
) (
    input logic                  clk,
    input logic                  resetn,
    input logic                  done,
    input logic                  busy,
    input logic [WIDTH-1:0]      result,
    input mont_pkg::ctrl_state_t state,
    input mont_pkg::acc_op_t     op,
    input mont_pkg::mult_sel_t   sel
);

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
        else $error("done stayed high for two cycles");

    busy_drops: assert property (@(posedge clk) disable iff (!resetn) done |=> !busy)
        else $error("busy still high in the cycle after done");

    idle_hold: assert property (@(posedge clk) disable iff (!resetn)
        (state == mont_pkg::ST_IDLE) |-> (op == mont_pkg::OP_HOLD))
        else $error("accumulator op other than HOLD while idle");

    // acc only changes once LOAD has run, so DONE and IDLE keep it
    result_hold: assert property (@(posedge clk) disable iff (!resetn)
        (state == mont_pkg::ST_DONE || state == mont_pkg::ST_IDLE) |=> $stable(result))
        else $error("result changed before the next accepted start");

    sel_b3: cover property (@(posedge clk) sel == mont_pkg::SEL_B3);
    sel_m2: cover property (@(posedge clk) sel == mont_pkg::SEL_M2);
    sel_m3: cover property (@(posedge clk) sel == mont_pkg::SEL_M3);

endmodule

bind mont_mul_top mont_mul_assert #(.WIDTH(WIDTH)) u_assert (
    .clk    (clk),
    .resetn (resetn),
    .done   (done),
    .busy   (busy),
    .result (result),
    .state  (u_ctrl.state),
    .op     (ctrl.op),
    .sel    (u_table.sel)
);

/* tests/mont_mul_tb.sv */
`timescale 1ns/1ps

module mont_mul_tb;

    localparam int WIDTH      = 64;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_OPS    = NUM_RANDOM + 8; // edge cases, busy test, quiet window
    localparam int TIMEOUT_NS = NUM_OPS * (WIDTH + 10) * 4 + 2000;

    logic             clk;
    logic             resetn;
    logic             start;
    logic [WIDTH-1:0] in_a;
    logic [WIDTH-1:0] in_b;
    logic [WIDTH-1:0] in_m;
    logic [WIDTH-1:0] result;
    logic             done;
    logic             busy;

    logic [63:0] rng_state;
    int          errors;
    int          checks;

    tb_clock #(.PERIOD(4), .RESET_CYCLES(5)) u_clock (
        .clk    (clk),
        .resetn (resetn)
    );

    mont_mul_top #(.WIDTH(WIDTH)) uut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic logic [63:0] next_rand();
        rng_state = xorshift64(rng_state);
        return rng_state;
    endfunction

    // bit-serial radix-2 reference, a*b*2^-WIDTH mod m
    function automatic logic [WIDTH-1:0] mont_model(input logic [WIDTH-1:0] a,
                                                    input logic [WIDTH-1:0] b,
                                                    input logic [WIDTH-1:0] m);
        logic [WIDTH+2:0] t;
        t = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (a[i]) t = t + {3'b000, b};
            if (t[0]) t = t + {3'b000, m}; // make it even before halving
            t = t >> 1;
        end
        if (t >= {3'b000, m}) t = t - {3'b000, m}; // t < 2m here
        return t[WIDTH-1:0];
    endfunction

    task automatic check_value(input string what, input logic [WIDTH-1:0] got,
                               input logic [WIDTH-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED time %0t: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // entered 1 ns after an edge with the DUT idle; disturb_at < 0 means no extra start
    task automatic run_op(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                          input logic [WIDTH-1:0] m, input int disturb_at,
                          output logic [WIDTH-1:0] res, output int cycles);
        cycles = 0;
        in_a   = a;
        in_b   = b;
        in_m   = m;
        start  = 1'b1;
        next_cycle(); // this edge samples start
        start  = 1'b0;
        while (done !== 1'b1 && cycles < 4 * WIDTH) begin
            check_value("busy during operation", WIDTH'(busy), WIDTH'(1));
            start = (cycles == disturb_at);
            if (start) begin
                in_a = ~a;
                in_b = ~b;
                in_m = m ^ WIDTH'(2);
            end
            next_cycle();
            cycles++;
        end
        start = 1'b0;
        res   = result;
        if (done !== 1'b1) begin
            errors++;
            $display("operation started at a=%h never raised done", a);
        end else begin
            check_value("busy at done", WIDTH'(busy), WIDTH'(1));
        end
        next_cycle(); // back to idle
        check_value("done pulse length", WIDTH'(done), WIDTH'(0));
        check_value("busy after done", WIDTH'(busy), WIDTH'(0));
        check_value("result held after done", result, res);
    endtask

    task automatic do_op(input string what, input logic [WIDTH-1:0] a,
                         input logic [WIDTH-1:0] b, input logic [WIDTH-1:0] m,
                         input int disturb_at);
        logic [WIDTH-1:0] res;
        logic [WIDTH-1:0] expected;
        int               cycles;
        expected = mont_model(a, b, m);
        run_op(a, b, m, disturb_at, res, cycles);
        check_value({what, " result"}, res, expected);
        check_value({what, " below m"}, WIDTH'(res < m), WIDTH'(1));
        check_value({what, " latency"}, WIDTH'(cycles), WIDTH'(WIDTH + 3));
    endtask

    function automatic logic [WIDTH-1:0] rand_modulus();
        return next_rand() | {1'b1, {(WIDTH - 2){1'b0}}, 1'b1}; // odd, top bit set
    endfunction

    initial begin
        logic [WIDTH-1:0] m;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        start     = 1'b0;
        in_a      = '0;
        in_b      = '0;
        in_m      = '0;
        rng_state = 64'd35;
        errors    = 0;
        checks    = 0;
        wait (resetn === 1'b1);
        next_cycle();

        repeat (3) begin
            check_value("done after reset", WIDTH'(done), WIDTH'(0));
            check_value("busy after reset", WIDTH'(busy), WIDTH'(0));
            next_cycle();
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            m = rand_modulus();
            a = next_rand() % m;
            b = next_rand() % m;
            do_op($sformatf("random op %0d", i), a, b, m, -1);
        end

        // corner operands hit the final subtraction
        m = rand_modulus();
        do_op("a zero", '0, next_rand() % m, m, -1);
        m = rand_modulus();
        do_op("a one", WIDTH'(1), next_rand() % m, m, -1);
        m = rand_modulus();
        do_op("b max", next_rand() % m, m - 1, m, -1);
        m = rand_modulus();
        do_op("a and b max", m - 1, m - 1, m, -1);

        m = rand_modulus();
        do_op("start while busy", next_rand() % m, next_rand() % m, m, 20);
        repeat (WIDTH + 8) begin
            check_value("no extra done", WIDTH'(done), WIDTH'(0));
            check_value("stays idle", WIDTH'(busy), WIDTH'(0));
            next_cycle();
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 resetn = 1'b1; // released just after an edge like every other input
    end

endmodule
